// File: verilog/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    // 3r format, full 17-bit major opcode
    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_IDLE    = 17'h00c91;
    // 2ri12 format, 10-bit opcode
    localparam logic [9:0]  OP_ADDI_W  = 10'h00a;
    localparam logic [9:0]  OP_LD_W    = 10'h0a2;
    localparam logic [9:0]  OP_ST_W    = 10'h0a6;
    // short opcodes, matched against the top of the 2ri12 opcode
    localparam logic [5:0]  OP_BEQ     = 6'b010110;
    localparam logic [5:0]  OP_BL      = 6'b010101;
    localparam logic [6:0]  OP_LU12I_W = 7'b0001010;

    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_3r;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_2ri12;
    } inst_word_u;

    typedef enum logic [2:0] {
        REG_TYPE_I    = 3'd0,
        REG_TYPE_RW   = 3'd1,
        REG_TYPE_RRW  = 3'd2,
        REG_TYPE_W    = 3'd3,
        REG_TYPE_RR   = 3'd4,
        REG_TYPE_BL   = 3'd5,
        REG_TYPE_IDLE = 3'd6
    } reg_type_e;

    typedef struct packed {
        logic [1:0][4:0] r_reg;
        logic [4:0]      w_reg;
    } reg_info_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
        reg_type_e   reg_type;
        reg_info_t   reg_info;
        logic        is_idle;
    } inst_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
    } raw_entry_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } ibus_req_t;

    // slot 0 holds the word at the lower address
    typedef struct packed {
        logic             valid;
        logic [1:0][31:0] data;
    } ibus_resp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

endpackage

`default_nettype wire

// File: verilog/npc.sv
`default_nettype none

module npc #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall_i,
    input  logic                    accept_i,
    input  frontend_pkg::redirect_t redirect_i,
    output logic [31:0]             pc_o
);
    import frontend_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] pc_next_pair;

    // next 8-byte boundary, drops bit 2 of a slot 1 target
    assign pc_next_pair = {pc_q[31:3] + 29'd1, 3'b000};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (redirect_i.valid) begin
            // redirect wins over stall and accept
            pc_q <= redirect_i.pc;
        end else if (accept_i && !stall_i) begin
            pc_q <= pc_next_pair;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [31:0]                    pc_i,
    input  logic                           stall_i,
    input  logic                           flush_i,
    output logic                           accept_o,
    output frontend_pkg::ibus_req_t        ibus_req_o,
    input  frontend_pkg::ibus_resp_t       ibus_resp_i,
    input  logic                           fifo_ready_i,
    output logic [1:0]                     write_num_o,
    output frontend_pkg::raw_entry_t [1:0] write_data_o
);
    import frontend_pkg::*;

    logic        busy;
    logic        drop;
    logic [31:0] req_pc;
    logic [31:0] pair_base;
    logic        slot0_valid;
    logic        resp_keep;

    // one transaction at a time, start only with room for a full pair
    assign accept_o = ~busy & ~stall_i & ~flush_i & fifo_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            drop <= 1'b0;
        end else begin
            if (accept_o) begin
                busy <= 1'b1;
            end else if (ibus_resp_i.valid) begin
                busy <= 1'b0;
            end
            // a flush with a request in flight makes its response stale
            if (ibus_resp_i.valid) begin
                drop <= 1'b0;
            end else if (flush_i && busy) begin
                drop <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_o) begin
            req_pc <= pc_i;
        end
    end

    assign pair_base = {req_pc[31:3], 3'b000};

    assign ibus_req_o.valid = busy;
    assign ibus_req_o.addr  = pair_base;

    // slot 0 is skipped when the target sits in the upper half
    assign slot0_valid = ~req_pc[2];
    assign resp_keep   = busy & ibus_resp_i.valid & ~drop & ~flush_i;

    always_comb begin
        write_num_o = 2'd0;
        if (resp_keep) begin
            write_num_o = slot0_valid ? 2'd2 : 2'd1;
        end
        // compact slot 1 into lane 0 for a lone upper word
        if (slot0_valid) begin
            write_data_o[0].pc   = pair_base;
            write_data_o[0].word = ibus_resp_i.data[0];
        end else begin
            write_data_o[0].pc   = {req_pc[31:3], 3'b100};
            write_data_o[0].word = ibus_resp_i.data[1];
        end
        write_data_o[1].pc   = {req_pc[31:3], 3'b100};
        write_data_o[1].word = ibus_resp_i.data[1];
    end

endmodule

`default_nettype wire

// File: verilog/multi_channel_fifo.sv
`default_nettype none

module multi_channel_fifo #(
    parameter int  DEPTH  = 4,
    parameter type DATA_T = logic [31:0]
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush_i,
    output logic        write_ready_o,
    input  logic [1:0]  write_num_i,
    input  DATA_T [1:0] write_data_i,
    output logic [1:0]  read_valid_o,
    input  logic        read_ready_i,
    input  logic [1:0]  read_num_i,
    output DATA_T [1:0] read_data_o
);
    localparam int SIZE  = 2 * DEPTH;
    localparam int PTR_W = $clog2(SIZE);
    localparam int CNT_W = $clog2(SIZE + 1);

    DATA_T            mem [SIZE];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr_1;
    logic [PTR_W-1:0] wr_ptr_1;
    logic [CNT_W-1:0] count;
    logic [1:0]       avail;
    logic [1:0]       push_num;
    logic [1:0]       pop_num;

    // circular pointer step, SIZE need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_add(
        input logic [PTR_W-1:0] ptr,
        input logic [1:0]       n
    );
        logic [PTR_W:0] sum;
        sum = {1'b0, ptr} + {{(PTR_W - 1){1'b0}}, n};
        if (sum >= (PTR_W + 1)'(SIZE)) begin
            sum = sum - (PTR_W + 1)'(SIZE);
        end
        return sum[PTR_W-1:0];
    endfunction

    assign rd_ptr_1 = ptr_add(rd_ptr, 2'd1);
    assign wr_ptr_1 = ptr_add(wr_ptr, 2'd1);

    // entries visible on the read lanes, capped at two
    assign avail         = (count >= CNT_W'(2)) ? 2'd2 : count[1:0];
    assign read_valid_o  = {avail[1], avail[1] | avail[0]};
    assign write_ready_o = (count <= CNT_W'(SIZE - 2));

    assign push_num = write_num_i;

    always_comb begin
        if (!read_ready_i) begin
            pop_num = 2'd0;
        end else if (read_num_i > avail) begin
            pop_num = avail;
        end else begin
            pop_num = read_num_i;
        end
    end

    assign read_data_o[0] = mem[rd_ptr];
    assign read_data_o[1] = mem[rd_ptr_1];

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= ptr_add(rd_ptr, pop_num);
            wr_ptr <= ptr_add(wr_ptr, push_num);
            count  <= count + CNT_W'(push_num) - CNT_W'(pop_num);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push_num != 2'd0) begin
            mem[wr_ptr] <= write_data_i[0];
        end
        if (push_num == 2'd2) begin
            mem[wr_ptr_1] <= write_data_i[1];
        end
    end

endmodule

`default_nettype wire

// File: verilog/decoder.sv
`default_nettype none

module decoder (
    input  frontend_pkg::inst_word_u inst_i,
    input  logic [31:0]              pc_i,
    output frontend_pkg::inst_t      inst_o
);
    import frontend_pkg::*;

    reg_type_e reg_type;
    reg_info_t reg_info;

    // opcode match, long 3r opcodes first
    always_comb begin
        reg_type = REG_TYPE_I;
        if (inst_i.fmt_3r.opcode == OP_ADD_W || inst_i.fmt_3r.opcode == OP_SUB_W) begin
            reg_type = REG_TYPE_RRW;
        end else if (inst_i.fmt_3r.opcode == OP_IDLE) begin
            reg_type = REG_TYPE_IDLE;
        end else if (inst_i.fmt_2ri12.opcode == OP_ADDI_W ||
                     inst_i.fmt_2ri12.opcode == OP_LD_W) begin
            reg_type = REG_TYPE_RW;
        end else if (inst_i.fmt_2ri12.opcode == OP_ST_W) begin
            reg_type = REG_TYPE_RR;
        end else if (inst_i.fmt_2ri12.opcode[9:4] == OP_BEQ) begin
            reg_type = REG_TYPE_RR;
        end else if (inst_i.fmt_2ri12.opcode[9:4] == OP_BL) begin
            reg_type = REG_TYPE_BL;
        end else if (inst_i.fmt_2ri12.opcode[9:3] == OP_LU12I_W) begin
            reg_type = REG_TYPE_W;
        end
    end

    // register fields by class, unused indices stay zero
    always_comb begin
        reg_info = '0;
        case (reg_type)
            REG_TYPE_RRW: begin
                reg_info.r_reg[0] = inst_i.fmt_3r.rk;
                reg_info.r_reg[1] = inst_i.fmt_3r.rj;
                reg_info.w_reg    = inst_i.fmt_3r.rd;
            end
            REG_TYPE_RW: begin
                reg_info.r_reg[1] = inst_i.fmt_2ri12.rj;
                reg_info.w_reg    = inst_i.fmt_2ri12.rd;
            end
            REG_TYPE_RR: begin
                // store data and beq both read rd
                reg_info.r_reg[0] = inst_i.fmt_2ri12.rd;
                reg_info.r_reg[1] = inst_i.fmt_2ri12.rj;
            end
            REG_TYPE_W: begin
                reg_info.w_reg = inst_i.fmt_2ri12.rd;
            end
            REG_TYPE_BL: begin
                // link register
                reg_info.w_reg = 5'd1;
            end
            default: begin
                reg_info = '0;
            end
        endcase
    end

    always_comb begin
        inst_o.pc       = pc_i;
        inst_o.word     = inst_i;
        inst_o.reg_type = reg_type;
        inst_o.reg_info = reg_info;
        inst_o.is_idle  = (reg_type == REG_TYPE_IDLE);
    end

endmodule

`default_nettype wire

// File: verilog/frontend.sv
`default_nettype none

module frontend #(
    parameter logic [31:0] RESET_PC  = 32'h1c00_0000,
    parameter int          RAW_DEPTH = 4,
    parameter int          DEC_DEPTH = 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output frontend_pkg::ibus_req_t   ibus_req_o,
    input  frontend_pkg::ibus_resp_t  ibus_resp_i,
    output frontend_pkg::inst_t [1:0] inst_o,
    output logic [1:0]                inst_valid_o,
    input  logic [1:0]                issue_num_i,
    input  logic                      backend_stall_i,
    input  frontend_pkg::redirect_t   redirect_i,
    input  logic                      irq_i
);
    import frontend_pkg::*;

    logic              flush;
    logic              fetch_stall;
    logic              idle_lock;
    logic              idle_popped;
    logic [31:0]       fetch_pc;
    logic              fetch_accept;
    logic              raw_ready;
    logic [1:0]        fetch_num;
    raw_entry_t [1:0]  fetch_data;
    logic [1:0]        raw_valid;
    raw_entry_t [1:0]  raw_data;
    logic [1:0]        move_num;
    logic              dec_ready;
    inst_t [1:0]       dec_inst;
    logic [1:0]        out_count;
    logic [1:0]        pop_num;

    assign flush = redirect_i.valid;

    // idle lock, held until an interrupt arrives
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idle_lock <= 1'b0;
        end else if (irq_i) begin
            idle_lock <= 1'b0;
        end else if (idle_popped) begin
            idle_lock <= 1'b1;
        end
    end

    assign fetch_stall = idle_lock;

    npc #(
        .RESET_PC(RESET_PC)
    ) npc_i (
        .clk,
        .rst_n,
        .stall_i   (fetch_stall),
        .accept_i  (fetch_accept),
        .redirect_i(redirect_i),
        .pc_o      (fetch_pc)
    );

    fetch_unit fetch_unit_i (
        .clk,
        .rst_n,
        .pc_i        (fetch_pc),
        .stall_i     (fetch_stall),
        .flush_i     (flush),
        .accept_o    (fetch_accept),
        .ibus_req_o  (ibus_req_o),
        .ibus_resp_i (ibus_resp_i),
        .fifo_ready_i(raw_ready),
        .write_num_o (fetch_num),
        .write_data_o(fetch_data)
    );

    multi_channel_fifo #(
        .DEPTH (RAW_DEPTH),
        .DATA_T(raw_entry_t)
    ) raw_fifo_i (
        .clk,
        .rst_n,
        .flush_i      (flush),
        .write_ready_o(raw_ready),
        .write_num_i  (fetch_num),
        .write_data_i (fetch_data),
        .read_valid_o (raw_valid),
        .read_ready_i (dec_ready),
        .read_num_i   (move_num),
        .read_data_o  (raw_data)
    );

    // move every valid raw entry once the decoded FIFO has room
    assign move_num = dec_ready ? {raw_valid[1] & raw_valid[0], raw_valid[1] ^ raw_valid[0]}
                                : 2'd0;

    for (genvar i = 0; i < 2; i++) begin : g_dec
        decoder decoder_i (
            .inst_i(raw_data[i].word),
            .pc_i  (raw_data[i].pc),
            .inst_o(dec_inst[i])
        );
    end

    multi_channel_fifo #(
        .DEPTH (DEC_DEPTH),
        .DATA_T(inst_t)
    ) dec_fifo_i (
        .clk,
        .rst_n,
        .flush_i      (flush),
        .write_ready_o(dec_ready),
        .write_num_i  (move_num),
        .write_data_i (dec_inst),
        .read_valid_o (inst_valid_o),
        .read_ready_i (~backend_stall_i),
        .read_num_i   (pop_num),
        .read_data_o  (inst_o)
    );

    // actual pop count, also used to spot a departing idle
    assign out_count = {inst_valid_o[1] & inst_valid_o[0], inst_valid_o[1] ^ inst_valid_o[0]};

    always_comb begin
        if (backend_stall_i) begin
            pop_num = 2'd0;
        end else if (issue_num_i > out_count) begin
            pop_num = out_count;
        end else begin
            pop_num = issue_num_i;
        end
    end

    assign idle_popped = ((pop_num != 2'd0) && inst_o[0].is_idle) ||
                         ((pop_num == 2'd2) && inst_o[1].is_idle);

endmodule

`default_nettype wire

// File: bench/inst_mem_model.sv
`default_nettype none

module inst_mem_model #(
    parameter int WORDS = 1024
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [1:0]               lat_i,
    input  frontend_pkg::ibus_req_t  req_i,
    output frontend_pkg::ibus_resp_t resp_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import frontend_pkg::*;

    // filled by the testbench before reset is released
    logic [31:0] mem [WORDS];

    logic       pending;
    logic [1:0] wait_cnt;
    logic [9:0] idx;

    // pair index, always even since the address is 8-byte aligned
    assign idx = req_i.addr[11:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending  <= 1'b0;
            wait_cnt <= 2'd0;
            resp_o   <= '0;
        end else begin
            resp_o.valid <= 1'b0;
            // the request is still high in the response cycle, skip it there
            if (req_i.valid && !resp_o.valid) begin
                if (!pending) begin
                    pending  <= 1'b1;
                    wait_cnt <= lat_i;
                end else if (wait_cnt == 2'd0) begin
                    pending        <= 1'b0;
                    resp_o.valid   <= 1'b1;
                    resp_o.data[0] <= mem[idx];
                    resp_o.data[1] <= mem[idx + 10'd1];
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/frontend_tb.sv
`default_nettype none

module frontend_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import frontend_pkg::*;

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;
    localparam int          N_POPS   = 600;
    localparam int          MAX_LAT  = 5;
    localparam longint      LIMIT_NS = longint'(N_POPS) * MAX_LAT * 8 * 40 + 20000;

    logic        clk;
    logic        rst_n;
    logic [1:0]  issue_num;
    logic        backend_stall;
    redirect_t   redirect;
    logic        irq;
    logic [1:0]  mem_lat;
    ibus_req_t   ibus_req;
    ibus_resp_t  ibus_resp;
    inst_t [1:0] inst;
    logic [1:0]  inst_valid;

    logic [15:0] lfsr = 16'd55307;
    logic [31:0] exp_pc = RESET_PC;
    logic [31:0] exp_addr = {RESET_PC[31:3], 3'b000};
    logic        req_prev = 1'b0;
    logic [31:0] req_addr_prev = '0;
    int          pop_count = 0;
    int          mismatch_errs = 0;
    int          other_errs = 0;
    logic        redirect_seen = 1'b0;
    logic        locked = 1'b0;
    logic        lock_drained = 1'b0;

    frontend #(
        .RESET_PC (RESET_PC),
        .RAW_DEPTH(4),
        .DEC_DEPTH(2)
    ) dut_i (
        .clk,
        .rst_n,
        .ibus_req_o     (ibus_req),
        .ibus_resp_i    (ibus_resp),
        .inst_o         (inst),
        .inst_valid_o   (inst_valid),
        .issue_num_i    (issue_num),
        .backend_stall_i(backend_stall),
        .redirect_i     (redirect),
        .irq_i          (irq)
    );

    inst_mem_model mem_i (
        .clk,
        .rst_n,
        .lat_i (mem_lat),
        .req_i (ibus_req),
        .resp_o(ibus_resp)
    );

    always #20 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_word(input int k);
        logic [2:0] sel;
        sel = 3'(take_bits(3));
        // idle only at fixed spots
        if (k % 97 == 50) begin
            return {OP_IDLE, 15'd0};
        end
        case (sel)
            3'd0: return {OP_ADD_W, 15'(take_bits(15))};
            3'd1: return {OP_SUB_W, 15'(take_bits(15))};
            3'd2: return {OP_ADDI_W, 22'(take_bits(22))};
            3'd3: return {OP_LD_W, 22'(take_bits(22))};
            3'd4: return {OP_ST_W, 22'(take_bits(22))};
            3'd5: return {OP_BEQ, 26'(take_bits(26))};
            3'd6: return {OP_BL, 26'(take_bits(26))};
            default: return {OP_LU12I_W, 25'(take_bits(25))};
        endcase
    endfunction

    // expected record for the word at pc
    function automatic inst_t ref_inst(input logic [31:0] pc);
        inst_t       r;
        logic [31:0] w;
        w          = mem_i.mem[pc[11:2]];
        r          = '0;
        r.pc       = pc;
        r.word     = w;
        r.reg_type = REG_TYPE_I;
        if (w[31:15] == OP_ADD_W || w[31:15] == OP_SUB_W) begin
            r.reg_type          = REG_TYPE_RRW;
            r.reg_info.r_reg[0] = w[14:10];
            r.reg_info.r_reg[1] = w[9:5];
            r.reg_info.w_reg    = w[4:0];
        end else if (w[31:15] == OP_IDLE) begin
            r.reg_type = REG_TYPE_IDLE;
        end else if (w[31:22] == OP_ADDI_W || w[31:22] == OP_LD_W) begin
            r.reg_type          = REG_TYPE_RW;
            r.reg_info.r_reg[1] = w[9:5];
            r.reg_info.w_reg    = w[4:0];
        end else if (w[31:22] == OP_ST_W || w[31:26] == OP_BEQ) begin
            r.reg_type          = REG_TYPE_RR;
            r.reg_info.r_reg[0] = w[4:0];
            r.reg_info.r_reg[1] = w[9:5];
        end else if (w[31:26] == OP_BL) begin
            r.reg_type       = REG_TYPE_BL;
            r.reg_info.w_reg = 5'd1;
        end else if (w[31:25] == OP_LU12I_W) begin
            r.reg_type       = REG_TYPE_W;
            r.reg_info.w_reg = w[4:0];
        end
        r.is_idle = (r.reg_type == REG_TYPE_IDLE);
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp) else begin
            mismatch_errs++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_lane(input int lane, input inst_t e);
        check_val($sformatf("inst_o[%0d].pc", lane), 64'(inst[lane].pc), 64'(e.pc));
        check_val($sformatf("inst_o[%0d].word", lane), 64'(inst[lane].word), 64'(e.word));
        check_val($sformatf("inst_o[%0d].reg_type", lane),
                  64'(inst[lane].reg_type), 64'(e.reg_type));
        check_val($sformatf("inst_o[%0d].reg_info", lane),
                  64'(inst[lane].reg_info), 64'(e.reg_info));
        check_val($sformatf("inst_o[%0d].is_idle", lane),
                  64'(inst[lane].is_idle), 64'(e.is_idle));
    endtask

    // comparator, samples the values that were present before the edge
    always @(posedge clk) begin : compare
        int    cnt;
        int    n;
        logic  idle_pop;
        inst_t e;
        if (rst_n) begin
            if (redirect_seen) begin
                assert (inst_valid == 2'b00) else begin
                    other_errs++;
                    $display("t=%0t output still valid right after a redirect", $time);
                end
            end
            assert (inst_valid != 2'b10) else begin
                other_errs++;
                $display("t=%0t lane 1 valid without lane 0", $time);
            end
            if (locked && lock_drained) begin
                assert (!ibus_req.valid) else begin
                    other_errs++;
                    $display("t=%0t bus request started while idle lock is held", $time);
                end
            end
            // a new request goes to the next pair, and holds its address
            if (ibus_req.valid && !req_prev) begin
                check_val("ibus_req_o.addr", 64'(ibus_req.addr), 64'(exp_addr));
                exp_addr = exp_addr + 32'd8;
            end else if (ibus_req.valid) begin
                check_val("ibus_req_o.addr", 64'(ibus_req.addr), 64'(req_addr_prev));
            end
            req_prev      = ibus_req.valid;
            req_addr_prev = ibus_req.addr;
            cnt      = int'(inst_valid[0]) + int'(inst_valid[1]);
            n        = backend_stall ? 0 : ((int'(issue_num) > cnt) ? cnt : int'(issue_num));
            idle_pop = 1'b0;
            for (int lane = 0; lane < n; lane++) begin
                e = ref_inst(exp_pc + 32'(4 * lane));
                if (e.is_idle) begin
                    idle_pop = 1'b1;
                end
                if (!redirect.valid) begin
                    check_lane(lane, e);
                    pop_count++;
                end
            end
            if (redirect.valid) begin
                exp_pc   = redirect.pc;
                exp_addr = {redirect.pc[31:3], 3'b000};
            end else begin
                exp_pc = exp_pc + 32'(4 * n);
            end
            redirect_seen = redirect.valid;
            if (locked && ibus_resp.valid) begin
                lock_drained = 1'b1;
            end
            // mirror of the idle lock
            if (irq) begin
                locked       = 1'b0;
                lock_drained = 1'b0;
            end else if (idle_pop) begin
                locked = 1'b1;
            end
        end
    end

    initial begin : stimulus
        logic [1:0] v;
        clk           = 1'b0;
        rst_n         = 1'b0;
        issue_num     = 2'd0;
        backend_stall = 1'b0;
        redirect      = '0;
        irq           = 1'b0;
        mem_lat       = 2'd0;
        for (int k = 0; k < 1024; k++) begin
            mem_i.mem[k] = make_word(k);
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        #1;
        assert (inst_valid == 2'b00 && !ibus_req.valid) else begin
            other_errs++;
            $display("t=%0t outputs not idle after reset", $time);
        end
        while (pop_count < N_POPS) begin
            @(posedge clk);
            v = 2'(take_bits(2));
            issue_num      <= (v == 2'd3) ? 2'd2 : v;
            backend_stall  <= (take_bits(3) == 0);
            mem_lat        <= 2'(take_bits(2));
            irq            <= (take_bits(5) == 0);
            redirect.valid <= (take_bits(5) == 0);
            redirect.pc    <= {RESET_PC[31:12], 10'(take_bits(10)), 2'b00};
        end
        redirect.valid <= 1'b0;
        repeat (4) @(posedge clk);
        $display("errors: mismatch=%0d other=%0d, pops checked=%0d",
                 mismatch_errs, other_errs, pop_count);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        #(LIMIT_NS);
        $display("timeout: only %0d of %0d pops seen", pop_count, N_POPS);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
verilog/frontend_pkg.sv
verilog/npc.sv
verilog/fetch_unit.sv
verilog/multi_channel_fifo.sv
verilog/decoder.sv
verilog/frontend.sv
bench/inst_mem_model.sv
bench/frontend_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= frontend_tb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
